// File: hdl/commit_pkg.sv
// commit stage package: data widths, code typedefs and opcode/unit encodings
package commit_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // default architectural data width, handed to the top level
    parameter int unsigned XLEN_DEFAULT = 64;

    // architectural integer register address
    typedef logic [4:0] reg_addr_t;

    // exception cause as seen by the controller
    typedef logic [5:0] cause_t;

    // ------------------------------------------------------------------------
    // functional units
    // ------------------------------------------------------------------------

    // unit that executed the instruction in the scoreboard entry
    typedef logic [3:0] fu_t;

    // no unit, e.g. a bubble or an instruction that faulted in decode
    localparam fu_t FU_NONE      = 4'd0;
    localparam fu_t FU_LOAD      = 4'd1;
    localparam fu_t FU_STORE     = 4'd2;
    localparam fu_t FU_ALU       = 4'd3;
    // branches and jumps
    localparam fu_t FU_CTRL_FLOW = 4'd4;
    localparam fu_t FU_MULT      = 4'd5;
    // csr accesses, fences and other system instructions
    localparam fu_t FU_CSR       = 4'd6;

    // ------------------------------------------------------------------------
    // operations
    // ------------------------------------------------------------------------

    // decoded operation of the scoreboard entry
    typedef logic [6:0] op_t;

    // plain add, also the no-op value on the csr operation port
    localparam op_t OP_ADD        = 7'd0;

    // csr read/modify/write group
    localparam op_t OP_CSRRW      = 7'd8;
    localparam op_t OP_CSRRS      = 7'd9;
    localparam op_t OP_CSRRC      = 7'd10;

    // memory ordering and cache/tlb maintenance
    localparam op_t OP_FENCE      = 7'd16;
    localparam op_t OP_FENCE_I    = 7'd17;
    localparam op_t OP_SFENCE_VMA = 7'd18;

    // doubleword load and store
    localparam op_t OP_LD         = 7'd32;
    localparam op_t OP_SD         = 7'd40;

    // NOTE the csr path forwards op codes unchanged, so the csr file must
    // decode these same values

endpackage

// File: hdl/commit_decode.sv
// commit decoder: sorts one commit-port instruction into retire-rule kinds
`timescale 1ns/1ps

module commit_decode (
    // functional unit of the scoreboard entry
    input  commit_pkg::fu_t fu_i,
    // decoded operation of the scoreboard entry
    input  commit_pkg::op_t op_i,
    // store that has to be handed to the store buffer
    output logic            is_store_o,
    // csr access that has to be committed to the csr file
    output logic            is_csr_o,
    // plain fence
    output logic            is_fence_o,
    // instruction fence
    output logic            is_fence_i_o,
    // tlb fence
    output logic            is_sfence_o,
    // unit allowed to retire on the second port
    output logic            dual_ok_o
);

    // ------------------------------------------------------------------------
    // unit based kinds
    // ------------------------------------------------------------------------

    // stores are told apart by the unit only
    assign is_store_o = (fu_i == commit_pkg::FU_STORE);

    // anything on the csr unit goes through the csr commit path
    assign is_csr_o   = (fu_i == commit_pkg::FU_CSR);

    // ------------------------------------------------------------------------
    // operation based kinds
    // ------------------------------------------------------------------------

    // the fences are matched on the op code alone
    assign is_fence_o   = (op_i == commit_pkg::OP_FENCE);
    assign is_fence_i_o = (op_i == commit_pkg::OP_FENCE_I);
    assign is_sfence_o  = (op_i == commit_pkg::OP_SFENCE_VMA);

    // ------------------------------------------------------------------------
    // second port qualification
    // ------------------------------------------------------------------------

    // only units without side effects outside the register file
    always_comb begin
        dual_ok_o = 1'b0;
        // stores and csr accesses have side effects and stay on port 0
        if (fu_i inside {commit_pkg::FU_ALU, commit_pkg::FU_LOAD,
                         commit_pkg::FU_CTRL_FLOW, commit_pkg::FU_MULT}) begin
            dual_ok_o = 1'b1;
        end
    end

endmodule

// File: hdl/commit_execute.sv
// commit execute block: retire rules, register write enables and side requests
`timescale 1ns/1ps

module commit_execute #(
    parameter int unsigned XLEN = 64
) (
    // port 0 scoreboard entry
    input  logic             instr0_valid_i,
    input  logic             instr0_ex_valid_i,
    input  commit_pkg::op_t  instr0_op_i,
    input  logic [XLEN-1:0]  instr0_result_i,
    // port 0 kind flags from the decoder
    input  logic             is_store0_i,
    input  logic             is_csr0_i,
    input  logic             is_fence0_i,
    input  logic             is_fence_i0_i,
    input  logic             is_sfence0_i,
    // port 1 scoreboard entry
    input  logic             instr1_valid_i,
    input  logic             instr1_ex_valid_i,
    input  logic             dual_ok1_i,
    // controller and debug
    input  logic             halt_i,
    input  logic             single_step_i,
    input  logic             flush_dcache_i,
    // store buffer status
    input  logic             commit_lsu_ready_i,
    input  logic             no_st_pending_i,
    // csr file reports an exception for the port 0 instruction
    input  logic             csr_ex_valid_i,
    // acknowledges back to the scoreboard
    output logic [1:0]       commit_ack_o,
    // integer register file write enables
    output logic [1:0]       we_gpr_o,
    // store buffer commit strobe
    output logic             commit_lsu_o,
    // csr file commit
    output logic             commit_csr_o,
    output commit_pkg::op_t  csr_op_o,
    output logic [XLEN-1:0]  csr_wdata_o,
    // flush requests to the controller
    output logic             fence_o,
    output logic             fence_i_o,
    output logic             sfence_vma_o
);

    // port 0 acknowledge that port 1 depends on
    logic ack0;

    // ------------------------------------------------------------------------
    // port 0
    // ------------------------------------------------------------------------

    always_comb begin
        ack0         = 1'b0;
        we_gpr_o[0]  = 1'b0;
        commit_lsu_o = 1'b0;
        commit_csr_o = 1'b0;
        // add doubles as a csr no-op
        csr_op_o     = commit_pkg::OP_ADD;
        csr_wdata_o  = '0;
        fence_o      = 1'b0;
        fence_i_o    = 1'b0;
        sfence_vma_o = 1'b0;

        // a faulting or halted instruction never retires here
        if (instr0_valid_i && !instr0_ex_valid_i && !halt_i) begin
            // baseline retire that writes rd
            ack0        = 1'b1;
            we_gpr_o[0] = 1'b1;

            // stores wait until the store buffer takes them
            if (is_store0_i) begin
                ack0         = commit_lsu_ready_i;
                commit_lsu_o = commit_lsu_ready_i;
            end

            // csr access whose operands go out even if the csr file faults
            if (is_csr0_i) begin
                csr_op_o    = instr0_op_i;
                csr_wdata_o = instr0_result_i;
                if (!csr_ex_valid_i) begin
                    commit_csr_o = 1'b1;
                end else begin
                    // the trap is taken instead and rd stays untouched
                    ack0        = 1'b0;
                    we_gpr_o[0] = 1'b0;
                end
            end

            // tlb flush once the store buffer has drained
            if (is_sfence0_i) begin
                ack0         = no_st_pending_i;
                sfence_vma_o = no_st_pending_i;
            end

            // fence.i or any non-store while a dcache flush is requested
            if (is_fence_i0_i || (flush_dcache_i && !is_store0_i)) begin
                ack0      = no_st_pending_i;
                fence_i_o = no_st_pending_i;
            end

            // plain fence flushes the dcache
            if (is_fence0_i) begin
                ack0    = no_st_pending_i;
                fence_o = no_st_pending_i;
            end
        end

        commit_ack_o[0] = ack0;
    end

    // ------------------------------------------------------------------------
    // port 1
    // ------------------------------------------------------------------------

    // port 1 only retires behind port 0 and never past a csr access,
    // a dcache flush or a single step
    always_comb begin
        commit_ack_o[1] = 1'b0;
        we_gpr_o[1]     = 1'b0;
        if (ack0 && !is_csr0_i && !flush_dcache_i && !single_step_i) begin
            // second instruction must itself be clean and side-effect free
            if (instr1_valid_i && !instr1_ex_valid_i && dual_ok1_i) begin
                commit_ack_o[1] = 1'b1;
                we_gpr_o[1]     = 1'b1;
            end
        end
    end

endmodule

// File: hdl/commit_result.sv
// commit result block: exception selection and port-0 write-back data
`timescale 1ns/1ps

module commit_result #(
    parameter int unsigned XLEN = 64
) (
    // port 0 scoreboard entry
    input  logic                 instr0_valid_i,
    input  logic                 instr0_ex_valid_i,
    input  commit_pkg::cause_t   instr0_ex_cause_i,
    input  logic [XLEN-1:0]      instr0_ex_tval_i,
    input  logic [XLEN-1:0]      instr0_result_i,
    // csr file response for the port 0 instruction
    input  logic                 csr_ex_valid_i,
    input  commit_pkg::cause_t   csr_ex_cause_i,
    input  logic [XLEN-1:0]      csr_rdata_i,
    // csr commit decision from the execute block
    input  logic                 commit_csr_i,
    input  logic                 halt_i,
    // exception to the controller
    output logic                 exception_valid_o,
    output commit_pkg::cause_t   exception_cause_o,
    output logic [XLEN-1:0]      exception_tval_o,
    // port 0 register write data
    output logic [XLEN-1:0]      wdata0_o
);

    // ------------------------------------------------------------------------
    // exception selection
    // ------------------------------------------------------------------------

    // interrupts are ordered in the csr file, only traps are ordered here
    always_comb begin
        exception_valid_o = 1'b0;
        exception_cause_o = '0;
        exception_tval_o  = '0;

        // only a valid head entry can trap
        if (instr0_valid_i) begin
            // csr trap, tval still holds the instruction bits from decode
            if (csr_ex_valid_i) begin
                exception_valid_o = 1'b1;
                exception_cause_o = csr_ex_cause_i;
                exception_tval_o  = instr0_ex_tval_i;
            end
            // earlier traps (e.g. fetch page faults) win over the csr trap
            if (instr0_ex_valid_i) begin
                exception_valid_o = 1'b1;
                exception_cause_o = instr0_ex_cause_i;
                exception_tval_o  = instr0_ex_tval_i;
            end
        end

        // halted core takes no trap, cause and tval are don't care then
        if (halt_i) begin
            exception_valid_o = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // write-back data
    // ------------------------------------------------------------------------

    // a committing csr access returns the old csr value to rd
    assign wdata0_o = commit_csr_i ? csr_rdata_i : instr0_result_i;

endmodule

// File: hdl/commit_stage.sv
// commit stage top: retires up to two scoreboard entries per cycle
`timescale 1ns/1ps

module commit_stage #(
    parameter int unsigned XLEN = commit_pkg::XLEN_DEFAULT
) (
    // port 0 scoreboard entry
    input  logic                   instr0_valid_i,
    input  commit_pkg::fu_t        instr0_fu_i,
    input  commit_pkg::op_t        instr0_op_i,
    input  commit_pkg::reg_addr_t  instr0_rd_i,
    input  logic [XLEN-1:0]        instr0_result_i,
    input  logic                   instr0_ex_valid_i,
    input  logic [XLEN-1:0]        instr0_pc_i,
    input  commit_pkg::cause_t     instr0_ex_cause_i,
    input  logic [XLEN-1:0]        instr0_ex_tval_i,
    // port 1 scoreboard entry
    input  logic                   instr1_valid_i,
    input  commit_pkg::fu_t        instr1_fu_i,
    input  commit_pkg::op_t        instr1_op_i,
    input  commit_pkg::reg_addr_t  instr1_rd_i,
    input  logic [XLEN-1:0]        instr1_result_i,
    input  logic                   instr1_ex_valid_i,
    // controller and debug
    input  logic                   halt_i,
    input  logic                   single_step_i,
    input  logic                   flush_dcache_i,
    // store buffer
    input  logic                   commit_lsu_ready_i,
    input  logic                   no_st_pending_i,
    // csr file
    input  logic [XLEN-1:0]        csr_rdata_i,
    input  logic                   csr_ex_valid_i,
    input  commit_pkg::cause_t     csr_ex_cause_i,
    // scoreboard acknowledges
    output logic [1:0]             commit_ack_o,
    // integer register file
    output commit_pkg::reg_addr_t  waddr_o0,
    output commit_pkg::reg_addr_t  waddr_o1,
    output logic [XLEN-1:0]        wdata_o0,
    output logic [XLEN-1:0]        wdata_o1,
    output logic [1:0]             we_gpr_o,
    // pc of the head entry for the csr file
    output logic [XLEN-1:0]        pc_o,
    // csr file commit
    output commit_pkg::op_t        csr_op_o,
    output logic [XLEN-1:0]        csr_wdata_o,
    output logic                   commit_csr_o,
    // store buffer commit
    output logic                   commit_lsu_o,
    // flush requests
    output logic                   fence_o,
    output logic                   fence_i_o,
    output logic                   sfence_vma_o,
    // exception to the controller
    output logic                   exception_valid_o,
    output commit_pkg::cause_t     exception_cause_o,
    output logic [XLEN-1:0]        exception_tval_o
);

    // port 0 kinds
    logic is_store0;
    logic is_csr0;
    logic is_fence0;
    logic is_fence_i0;
    logic is_sfence0;
    // port 1 may retire alongside port 0
    logic dual_ok1;
    // csr commit decision, selects the port 0 write data
    logic commit_csr;

    // ------------------------------------------------------------------------
    // pass-through fields
    // ------------------------------------------------------------------------

    assign waddr_o0     = instr0_rd_i;
    assign waddr_o1     = instr1_rd_i;
    // port 1 never carries a csr result
    assign wdata_o1     = instr1_result_i;
    assign pc_o         = instr0_pc_i;
    assign commit_csr_o = commit_csr;

    // ------------------------------------------------------------------------
    // decoders
    // ------------------------------------------------------------------------

    commit_decode i_decode0 (
        .fu_i         (instr0_fu_i),
        .op_i         (instr0_op_i),
        .is_store_o   (is_store0),
        .is_csr_o     (is_csr0),
        .is_fence_o   (is_fence0),
        .is_fence_i_o (is_fence_i0),
        .is_sfence_o  (is_sfence0),
        // port 0 retires any unit
        .dual_ok_o    ()
    );

    // port 1 only needs the second-port qualification
    commit_decode i_decode1 (
        .fu_i         (instr1_fu_i),
        .op_i         (instr1_op_i),
        .is_store_o   (),
        .is_csr_o     (),
        .is_fence_o   (),
        .is_fence_i_o (),
        .is_sfence_o  (),
        .dual_ok_o    (dual_ok1)
    );

    // ------------------------------------------------------------------------
    // retire rules and result selection
    // ------------------------------------------------------------------------

    commit_execute #(.XLEN(XLEN)) i_execute (
        .instr0_valid_i     (instr0_valid_i),
        .instr0_ex_valid_i  (instr0_ex_valid_i),
        .instr0_op_i        (instr0_op_i),
        .instr0_result_i    (instr0_result_i),
        .is_store0_i        (is_store0),
        .is_csr0_i          (is_csr0),
        .is_fence0_i        (is_fence0),
        .is_fence_i0_i      (is_fence_i0),
        .is_sfence0_i       (is_sfence0),
        .instr1_valid_i     (instr1_valid_i),
        .instr1_ex_valid_i  (instr1_ex_valid_i),
        .dual_ok1_i         (dual_ok1),
        .halt_i             (halt_i),
        .single_step_i      (single_step_i),
        .flush_dcache_i     (flush_dcache_i),
        .commit_lsu_ready_i (commit_lsu_ready_i),
        .no_st_pending_i    (no_st_pending_i),
        .csr_ex_valid_i     (csr_ex_valid_i),
        .commit_ack_o       (commit_ack_o),
        .we_gpr_o           (we_gpr_o),
        .commit_lsu_o       (commit_lsu_o),
        .commit_csr_o       (commit_csr),
        .csr_op_o           (csr_op_o),
        .csr_wdata_o        (csr_wdata_o),
        .fence_o            (fence_o),
        .fence_i_o          (fence_i_o),
        .sfence_vma_o       (sfence_vma_o)
    );

    commit_result #(.XLEN(XLEN)) i_result (
        .instr0_valid_i    (instr0_valid_i),
        .instr0_ex_valid_i (instr0_ex_valid_i),
        .instr0_ex_cause_i (instr0_ex_cause_i),
        .instr0_ex_tval_i  (instr0_ex_tval_i),
        .instr0_result_i   (instr0_result_i),
        .csr_ex_valid_i    (csr_ex_valid_i),
        .csr_ex_cause_i    (csr_ex_cause_i),
        .csr_rdata_i       (csr_rdata_i),
        .commit_csr_i      (commit_csr),
        .halt_i            (halt_i),
        .exception_valid_o (exception_valid_o),
        .exception_cause_o (exception_cause_o),
        .exception_tval_o  (exception_tval_o),
        .wdata0_o          (wdata_o0)
    );

endmodule

// File: tests/tb_commit_stage.sv
// commit stage testbench: directed retire, back-pressure, csr, fence and trap checks
`timescale 1ns/1ps

module tb_commit_stage;

    localparam int unsigned XLEN = commit_pkg::XLEN_DEFAULT;

    logic clk_i = 1'b0;
    logic rst_i = 1'b1;
    integer seed = 82655;

    // dut inputs
    logic instr0_valid_i, instr0_ex_valid_i, instr1_valid_i, instr1_ex_valid_i;
    commit_pkg::fu_t instr0_fu_i, instr1_fu_i;
    commit_pkg::op_t instr0_op_i, instr1_op_i;
    commit_pkg::reg_addr_t instr0_rd_i, instr1_rd_i;
    logic [XLEN-1:0] instr0_result_i, instr1_result_i, instr0_pc_i, instr0_ex_tval_i;
    commit_pkg::cause_t instr0_ex_cause_i, csr_ex_cause_i;
    logic halt_i, single_step_i, flush_dcache_i, commit_lsu_ready_i, no_st_pending_i;
    logic [XLEN-1:0] csr_rdata_i;
    logic csr_ex_valid_i;
    // dut outputs
    logic [1:0] commit_ack_o, we_gpr_o;
    commit_pkg::reg_addr_t waddr_o0, waddr_o1;
    logic [XLEN-1:0] wdata_o0, wdata_o1, pc_o, csr_wdata_o, exception_tval_o;
    commit_pkg::op_t csr_op_o;
    commit_pkg::cause_t exception_cause_o;
    logic commit_csr_o, commit_lsu_o, fence_o, fence_i_o, sfence_vma_o, exception_valid_o;

    // 4 ns clock only paces stimulus and sampling since the dut is combinational
    always #2 clk_i = ~clk_i;

    commit_stage #(.XLEN(XLEN)) i_commit_stage (.*);

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    function automatic commit_pkg::cause_t rand_cause();
        logic [31:0] r;
        r = $random(seed);
        return r[5:0];
    endfunction

    // empty head entries, store buffer drained and ready
    task automatic drive_idle();
        instr0_valid_i = 1'b0;
        instr0_ex_valid_i = 1'b0;
        instr1_valid_i = 1'b0;
        instr1_ex_valid_i = 1'b0;
        instr0_fu_i = commit_pkg::FU_NONE;
        instr1_fu_i = commit_pkg::FU_NONE;
        instr0_op_i = commit_pkg::OP_ADD;
        instr1_op_i = commit_pkg::OP_ADD;
        instr0_rd_i = '0;
        instr1_rd_i = '0;
        instr0_result_i = '0;
        instr1_result_i = '0;
        instr0_pc_i = '0;
        instr0_ex_tval_i = '0;
        instr0_ex_cause_i = '0;
        halt_i = 1'b0;
        single_step_i = 1'b0;
        flush_dcache_i = 1'b0;
        commit_lsu_ready_i = 1'b1;
        no_st_pending_i = 1'b1;
        csr_rdata_i = '0;
        csr_ex_valid_i = 1'b0;
        csr_ex_cause_i = '0;
    endtask

    // drive on the falling edge and sample 1 ns before the rising edge
    task automatic next_cycle();
        @(negedge clk_i);
    endtask

    task automatic settle();
        #1;
    endtask

    task automatic expect_quiet();
        check("commit_ack_o", 64'(commit_ack_o), 64'h0);
        check("we_gpr_o", 64'(we_gpr_o), 64'h0);
        check("strobes", 64'({commit_csr_o, commit_lsu_o, fence_o, fence_i_o, sfence_vma_o}),
              64'h0);
        check("exception_valid_o", 64'(exception_valid_o), 64'h0);
    endtask

    task automatic wait_ack0(input string what);
        int cycles;
        cycles = 0;
        settle();
        while (commit_ack_o[0] !== 1'b1 && cycles < 20) begin
            next_cycle();
            settle();
            cycles++;
        end
        if (commit_ack_o[0] !== 1'b1) begin
            $display("timeout: the %s on port 0 never retired within 20 cycles", what);
            $display("Some tests failed");
            $fatal(1, "retire timeout");
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------

    task automatic test_dual_retire();
        next_cycle();
        drive_idle();
        instr0_valid_i = 1'b1;
        instr0_fu_i = commit_pkg::FU_ALU;
        instr0_rd_i = 5'd7;
        instr0_result_i = rand_word();
        instr0_pc_i = rand_word();
        instr1_valid_i = 1'b1;
        instr1_fu_i = commit_pkg::FU_LOAD;
        instr1_op_i = commit_pkg::OP_LD;
        instr1_rd_i = 5'd19;
        instr1_result_i = rand_word();
        settle();
        check("commit_ack_o", 64'(commit_ack_o), 64'h3);
        check("we_gpr_o", 64'(we_gpr_o), 64'h3);
        check("waddr_o0", 64'(waddr_o0), 64'd7);
        check("waddr_o1", 64'(waddr_o1), 64'd19);
        check("wdata_o0", wdata_o0, instr0_result_i);
        check("wdata_o1", wdata_o1, instr1_result_i);
        check("pc_o", pc_o, instr0_pc_i);
        // single step lets only the head retire
        next_cycle();
        single_step_i = 1'b1;
        settle();
        check("commit_ack_o", 64'(commit_ack_o), 64'h1);
        check("we_gpr_o", 64'(we_gpr_o), 64'h1);
        next_cycle();
        single_step_i = 1'b0;
        halt_i = 1'b1;
        settle();
        check("commit_ack_o", 64'(commit_ack_o), 64'h0);
        check("we_gpr_o", 64'(we_gpr_o), 64'h0);
    endtask

    task automatic test_store_backpressure();
        next_cycle();
        drive_idle();
        instr0_valid_i = 1'b1;
        instr0_fu_i = commit_pkg::FU_STORE;
        instr0_op_i = commit_pkg::OP_SD;
        instr0_result_i = rand_word();
        instr1_valid_i = 1'b1;
        instr1_fu_i = commit_pkg::FU_ALU;
        instr1_rd_i = 5'd3;
        commit_lsu_ready_i = 1'b0;
        settle();
        check("commit_ack_o", 64'(commit_ack_o), 64'h0);
        check("commit_lsu_o", 64'(commit_lsu_o), 64'h0);
        next_cycle();
        commit_lsu_ready_i = 1'b1;
        wait_ack0("store");
        check("commit_ack_o", 64'(commit_ack_o), 64'h3);
        check("commit_lsu_o", 64'(commit_lsu_o), 64'h1);
        check("we_gpr_o[1]", 64'(we_gpr_o[1]), 64'h1);
    endtask

    task automatic test_csr_commit();
        next_cycle();
        drive_idle();
        instr0_valid_i = 1'b1;
        instr0_fu_i = commit_pkg::FU_CSR;
        instr0_op_i = commit_pkg::OP_CSRRW;
        instr0_rd_i = 5'd11;
        instr0_result_i = rand_word();
        instr0_ex_tval_i = rand_word();
        csr_rdata_i = rand_word();
        instr1_valid_i = 1'b1;
        instr1_fu_i = commit_pkg::FU_ALU;
        settle();
        check("commit_csr_o", 64'(commit_csr_o), 64'h1);
        check("commit_ack_o", 64'(commit_ack_o), 64'h1);
        check("we_gpr_o", 64'(we_gpr_o), 64'h1);
        check("wdata_o0", wdata_o0, csr_rdata_i);
        check("csr_op_o", 64'(csr_op_o), 64'(commit_pkg::OP_CSRRW));
        check("csr_wdata_o", csr_wdata_o, instr0_result_i);
        check("exception_valid_o", 64'(exception_valid_o), 64'h0);
        // csr file faults and the trap takes the instruction's tval
        next_cycle();
        csr_ex_valid_i = 1'b1;
        csr_ex_cause_i = rand_cause();
        settle();
        check("commit_ack_o", 64'(commit_ack_o), 64'h0);
        check("we_gpr_o", 64'(we_gpr_o), 64'h0);
        check("commit_csr_o", 64'(commit_csr_o), 64'h0);
        check("exception_valid_o", 64'(exception_valid_o), 64'h1);
        check("exception_cause_o", 64'(exception_cause_o), 64'(csr_ex_cause_i));
        check("exception_tval_o", exception_tval_o, instr0_ex_tval_i);
    endtask

    // req is the expected {fence, fence.i, sfence.vma} vector once drained
    task automatic fence_case(input commit_pkg::fu_t fu, input commit_pkg::op_t op,
                              input logic flush, input logic [2:0] req, input string what);
        next_cycle();
        drive_idle();
        instr0_valid_i = 1'b1;
        instr0_fu_i = fu;
        instr0_op_i = op;
        instr1_valid_i = 1'b1;
        instr1_fu_i = commit_pkg::FU_ALU;
        flush_dcache_i = flush;
        no_st_pending_i = 1'b0;
        settle();
        check("commit_ack_o[0]", 64'(commit_ack_o[0]), 64'h0);
        check("fence requests", 64'({fence_o, fence_i_o, sfence_vma_o}), 64'h0);
        next_cycle();
        no_st_pending_i = 1'b1;
        wait_ack0(what);
        check("fence requests", 64'({fence_o, fence_i_o, sfence_vma_o}), 64'(req));
        // with a dcache flush requested port 1 stays behind
        if (flush) begin
            check("commit_ack_o[1]", 64'(commit_ack_o[1]), 64'h0);
        end
    endtask

    task automatic test_fences();
        fence_case(commit_pkg::FU_NONE, commit_pkg::OP_FENCE, 1'b0, 3'b100, "fence");
        fence_case(commit_pkg::FU_NONE, commit_pkg::OP_FENCE_I, 1'b0, 3'b010, "fence.i");
        fence_case(commit_pkg::FU_NONE, commit_pkg::OP_SFENCE_VMA, 1'b0, 3'b001, "sfence.vma");
        fence_case(commit_pkg::FU_ALU, commit_pkg::OP_ADD, 1'b1, 3'b010, "alu under flush");
    endtask

    task automatic test_exception_priority();
        next_cycle();
        drive_idle();
        instr0_valid_i = 1'b1;
        instr0_fu_i = commit_pkg::FU_ALU;
        instr0_ex_valid_i = 1'b1;
        instr0_ex_cause_i = rand_cause();
        instr0_ex_tval_i = rand_word();
        csr_ex_valid_i = 1'b1;
        csr_ex_cause_i = ~instr0_ex_cause_i;
        settle();
        check("exception_valid_o", 64'(exception_valid_o), 64'h1);
        check("exception_cause_o", 64'(exception_cause_o), 64'(instr0_ex_cause_i));
        check("exception_tval_o", exception_tval_o, instr0_ex_tval_i);
        check("commit_ack_o", 64'(commit_ack_o), 64'h0);
        next_cycle();
        halt_i = 1'b1;
        settle();
        check("exception_valid_o", 64'(exception_valid_o), 64'h0);
    endtask

    // ------------------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------------------

    initial begin
        drive_idle();
        // nothing may retire or trap while the heads are empty
        repeat (5) begin
            next_cycle();
            settle();
            expect_quiet();
        end
        next_cycle();
        rst_i = 1'b0;
        test_dual_retire();
        test_store_backpressure();
        test_csr_commit();
        test_fences();
        test_exception_priority();
        $display("All tests passed");
        $finish;
    end

endmodule

// File: filelist.f
hdl/commit_pkg.sv
hdl/commit_decode.sv
hdl/commit_execute.sv
hdl/commit_result.sv
hdl/commit_stage.sv
tests/tb_commit_stage.sv

// File: Makefile
# Verilator build and run of the commit stage testbench

VERILATOR ?= verilator
TOP       ?= tb_commit_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test: $(SIM_BIN)
	./$(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
